// ==== hw/video_pkg.sv ====
`default_nettype none

package video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Pixel and mode types
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef logic [3:0] mode_t;

	localparam int NUM_MODES = 13;
	localparam int COORD_W = 12; // Raster counters and coordinates

	// Mode numbers, in button order
	localparam mode_t MODE_BLACK       = 4'd0;
	localparam mode_t MODE_WHITE       = 4'd1;
	localparam mode_t MODE_RED         = 4'd2;
	localparam mode_t MODE_GREEN       = 4'd3;
	localparam mode_t MODE_BLUE        = 4'd4;
	localparam mode_t MODE_GRID_FINE   = 4'd5;
	localparam mode_t MODE_GRID_COARSE = 4'd6;
	localparam mode_t MODE_RAMP_H      = 4'd7;
	localparam mode_t MODE_RAMP_V      = 4'd8;
	localparam mode_t MODE_RAMP_RED    = 4'd9;
	localparam mode_t MODE_RAMP_GREEN  = 4'd10;
	localparam mode_t MODE_RAMP_BLUE   = 4'd11;
	localparam mode_t MODE_BARS        = 4'd12;

	////////////////////////////////////////////////////////////////////////////
	// Colour constants
	////////////////////////////////////////////////////////////////////////////

	localparam rgb_t COLOUR_BLACK   = '{red: 8'h00, green: 8'h00, blue: 8'h00};
	localparam rgb_t COLOUR_WHITE   = '{red: 8'hff, green: 8'hff, blue: 8'hff};
	localparam rgb_t COLOUR_RED     = '{red: 8'hff, green: 8'h00, blue: 8'h00};
	localparam rgb_t COLOUR_GREEN   = '{red: 8'h00, green: 8'hff, blue: 8'h00};
	localparam rgb_t COLOUR_BLUE    = '{red: 8'h00, green: 8'h00, blue: 8'hff};
	localparam rgb_t COLOUR_MAGENTA = '{red: 8'hff, green: 8'h00, blue: 8'hff};
	localparam rgb_t COLOUR_YELLOW  = '{red: 8'hff, green: 8'hff, blue: 8'h00};
	localparam rgb_t COLOUR_CYAN    = '{red: 8'h00, green: 8'hff, blue: 8'hff};

	// Left to right across the screen
	localparam rgb_t BAR_COLOURS [8] = '{
		COLOUR_RED, COLOUR_GREEN, COLOUR_BLUE, COLOUR_MAGENTA,
		COLOUR_YELLOW, COLOUR_CYAN, COLOUR_WHITE, COLOUR_BLACK
	};

endpackage

`default_nettype wire

// ==== hw/video_timing.sv ====
`default_nettype none

module video_timing #(
	parameter int H_ACTIVE = 1280,
	parameter int H_FRONT  = 110,
	parameter int H_SYNC   = 40,
	parameter int H_BACK   = 220,
	parameter int V_ACTIVE = 720,
	parameter int V_FRONT  = 5,
	parameter int V_SYNC   = 5,
	parameter int V_BACK   = 20
) (
	input  wire                              reset,
	input  wire                              pix_clk,
	output logic                             hsync,
	output logic                             vsync,
	output logic                             de,
	output logic [video_pkg::COORD_W-1:0]    col,
	output logic [video_pkg::COORD_W-1:0]    row,
	output logic                             frame_start
);
	import video_pkg::*;

	// Line order is sync, back porch, active, front porch
	localparam int H_START = H_SYNC + H_BACK;
	localparam int H_END   = H_START + H_ACTIVE;
	localparam int H_TOTAL = H_END + H_FRONT;
	localparam int V_START = V_SYNC + V_BACK;
	localparam int V_END   = V_START + V_ACTIVE;
	localparam int V_TOTAL = V_END + V_FRONT;

	logic [COORD_W-1:0] h_pos;
	logic [COORD_W-1:0] v_pos;
	logic               h_last;
	logic               h_in_active;
	logic               v_in_active;

	////////////////////////////////////////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////////////////////////////////////////

	assign h_last = (h_pos == COORD_W'(H_TOTAL - 1));

	always_ff @(posedge pix_clk) begin
		if (reset) begin
			h_pos <= '0;
			v_pos <= '0;
		end else if (h_last) begin
			h_pos <= '0;
			if (v_pos == COORD_W'(V_TOTAL - 1))
				v_pos <= '0; // End of frame
			else
				v_pos <= v_pos + 1'b1;
		end else begin
			h_pos <= h_pos + 1'b1;
		end
	end

	assign h_in_active = (h_pos >= COORD_W'(H_START)) && (h_pos < COORD_W'(H_END));
	assign v_in_active = (v_pos >= COORD_W'(V_START)) && (v_pos < COORD_W'(V_END));

	////////////////////////////////////////////////////////////////////////////
	// Registered sync, enable and coordinates
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pix_clk) begin
		if (reset) begin
			hsync       <= 1'b1; // Inactive high
			vsync       <= 1'b1;
			de          <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			hsync       <= !(h_pos < COORD_W'(H_SYNC));
			vsync       <= !(v_pos < COORD_W'(V_SYNC));
			de          <= h_in_active && v_in_active;
			frame_start <= (h_pos == '0) && (v_pos == '0);
		end
	end

	// Only meaningful while de is high
	always_ff @(posedge pix_clk) begin
		col <= h_pos - COORD_W'(H_START);
		row <= v_pos - COORD_W'(V_START);
	end

endmodule

`default_nettype wire

// ==== hw/mode_select.sv ====
`default_nettype none

module mode_select #(
	parameter int DEBOUNCE_CYCLES = 71428
) (
	input  wire                   pix_clk,
	input  wire                   reset,
	input  wire                   button,
	output video_pkg::mode_t      next_mode
);
	import video_pkg::*;

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [1:0]       button_sync; // Button is asynchronous to pix_clk
	logic [CNT_W-1:0] press_cnt;
	logic             pressed;
	logic             step;

	assign pressed = button_sync[1];

	always_ff @(posedge pix_clk) begin
		if (reset)
			button_sync <= 2'b00;
		else
			button_sync <= {button_sync[0], button};
	end

	// Counter holds at the limit until release
	assign step = pressed && (press_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

	always_ff @(posedge pix_clk) begin
		if (reset || !pressed)
			press_cnt <= '0;
		else if (press_cnt != CNT_W'(DEBOUNCE_CYCLES))
			press_cnt <= press_cnt + 1'b1;
	end

	always_ff @(posedge pix_clk) begin
		if (reset) begin
			next_mode <= MODE_BLACK;
		end else if (step) begin
			if (next_mode == mode_t'(NUM_MODES - 1))
				next_mode <= MODE_BLACK; // Wrap after colour bars
			else
				next_mode <= next_mode + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pattern_gen.sv ====
`default_nettype none

module pattern_gen #(
	parameter int H_ACTIVE = 1280
) (
	input  wire                              pix_clk,
	input  wire                              reset,
	input  wire video_pkg::mode_t            next_mode,
	input  wire                              frame_start,
	input  wire [video_pkg::COORD_W-1:0]     col,
	input  wire [video_pkg::COORD_W-1:0]     row,
	input  wire                              hsync_in,
	input  wire                              vsync_in,
	input  wire                              de_in,
	output video_pkg::mode_t                 mode,
	output video_pkg::rgb_t                  pixel,
	output logic                             hsync_d,
	output logic                             vsync_d,
	output logic                             de_d
);
	import video_pkg::*;

	localparam int BAR_W = H_ACTIVE / 8; // Pixels per colour bar

	logic [7:0]         grid_fine;
	logic [7:0]         grid_coarse;
	logic [7:0]         ramp_h;
	logic [7:0]         ramp_v;
	logic [COORD_W-1:0] bar_idx;
	logic [2:0]         bar_sel;
	rgb_t               pix_next;

	// Mode only changes between frames
	always_ff @(posedge pix_clk) begin
		if (reset)
			mode <= MODE_BLACK;
		else if (frame_start)
			mode <= next_mode;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pattern terms
	////////////////////////////////////////////////////////////////////////////

	assign grid_fine   = (col[4] ^ row[4]) ? 8'h00 : 8'hff;
	assign grid_coarse = (col[6] ^ row[6]) ? 8'h00 : 8'hff;
	assign ramp_h      = col[7:0];
	assign ramp_v      = row[8:1]; // Half rate so 512 lines span the ramp

	assign bar_idx = col / COORD_W'(BAR_W);
	assign bar_sel = (bar_idx > COORD_W'(7)) ? 3'd7 : bar_idx[2:0]; // Leftover columns

	always_comb begin
		case (mode)
			MODE_BLACK:       pix_next = COLOUR_BLACK;
			MODE_WHITE:       pix_next = COLOUR_WHITE;
			MODE_RED:         pix_next = COLOUR_RED;
			MODE_GREEN:       pix_next = COLOUR_GREEN;
			MODE_BLUE:        pix_next = COLOUR_BLUE;
			MODE_GRID_FINE:   pix_next = '{grid_fine, grid_fine, grid_fine};
			MODE_GRID_COARSE: pix_next = '{grid_coarse, grid_coarse, grid_coarse};
			MODE_RAMP_H:      pix_next = '{ramp_h, ramp_h, ramp_h};
			MODE_RAMP_V:      pix_next = '{ramp_v, ramp_v, ramp_v};
			MODE_RAMP_RED:    pix_next = '{ramp_h, 8'h00, 8'h00};
			MODE_RAMP_GREEN:  pix_next = '{8'h00, ramp_h, 8'h00};
			MODE_RAMP_BLUE:   pix_next = '{8'h00, 8'h00, ramp_h};
			MODE_BARS:        pix_next = BAR_COLOURS[bar_sel];
			default:          pix_next = COLOUR_BLACK;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pix_clk) begin
		pixel <= pix_next;
	end

	// Keep sync and enable in step with the pixel
	always_ff @(posedge pix_clk) begin
		if (reset) begin
			hsync_d <= 1'b1;
			vsync_d <= 1'b1;
			de_d    <= 1'b0;
		end else begin
			hsync_d <= hsync_in;
			vsync_d <= vsync_in;
			de_d    <= de_in;
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_out.sv ====
`default_nettype none

module video_out (
	input  wire                  pix_clk,
	input  wire                  reset,
	input  wire video_pkg::rgb_t pixel,
	input  wire                  hsync_in,
	input  wire                  vsync_in,
	input  wire                  de_in,
	output logic [7:0]           red,
	output logic [7:0]           green,
	output logic [7:0]           blue,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 de
);

	////////////////////////////////////////////////////////////////////////////
	// Pin registers, nothing combinational reaches the transmitter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pix_clk) begin
		if (reset) begin
			red   <= 8'h00;
			green <= 8'h00;
			blue  <= 8'h00;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de    <= 1'b0;
		end else begin
			hsync <= hsync_in;
			vsync <= vsync_in;
			de    <= de_in;
			if (de_in) begin
				red   <= pixel.red;
				green <= pixel.green;
				blue  <= pixel.blue;
			end else begin
				red   <= 8'h00; // Blanking
				green <= 8'h00;
				blue  <= 8'h00;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/hdmi_pattern_top.sv ====
`default_nettype none

module hdmi_pattern_top #(
	parameter int H_ACTIVE        = 1280,
	parameter int H_FRONT         = 110,
	parameter int H_SYNC          = 40,
	parameter int H_BACK          = 220,
	parameter int V_ACTIVE        = 720,
	parameter int V_FRONT         = 5,
	parameter int V_SYNC          = 5,
	parameter int V_BACK          = 20,
	parameter int DEBOUNCE_CYCLES = 71428 // About 1 ms at 74.25 MHz
) (
	input  wire                  pix_clk,
	input  wire                  reset,
	input  wire                  button,
	output logic [7:0]           red,
	output logic [7:0]           green,
	output logic [7:0]           blue,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 de,
	output video_pkg::mode_t     mode
);
	import video_pkg::*;

	// Stage 0, from the raster counters
	logic               t_hsync;
	logic               t_vsync;
	logic               t_de;
	logic [COORD_W-1:0] col;
	logic [COORD_W-1:0] row;
	logic               frame_start;
	mode_t              next_mode;
	// Stage 1, from the pattern generator
	rgb_t               pixel;
	logic               p_hsync;
	logic               p_vsync;
	logic               p_de;

	video_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) video_timing_inst (
		.reset       (reset),
		.pix_clk     (pix_clk),
		.hsync       (t_hsync),
		.vsync       (t_vsync),
		.de          (t_de),
		.col         (col),
		.row         (row),
		.frame_start (frame_start)
	);

	mode_select #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) mode_select_inst (
		.pix_clk   (pix_clk),
		.reset     (reset),
		.button    (button),
		.next_mode (next_mode)
	);

	pattern_gen #(
		.H_ACTIVE (H_ACTIVE)
	) pattern_gen_inst (
		.pix_clk     (pix_clk),
		.reset       (reset),
		.next_mode   (next_mode),
		.frame_start (frame_start),
		.col         (col),
		.row         (row),
		.hsync_in    (t_hsync),
		.vsync_in    (t_vsync),
		.de_in       (t_de),
		.mode        (mode),
		.pixel       (pixel),
		.hsync_d     (p_hsync),
		.vsync_d     (p_vsync),
		.de_d        (p_de)
	);

	video_out video_out_inst (
		.pix_clk  (pix_clk),
		.reset    (reset),
		.pixel    (pixel),
		.hsync_in (p_hsync),
		.vsync_in (p_vsync),
		.de_in    (p_de),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.hsync    (hsync),
		.vsync    (vsync),
		.de       (de)
	);

endmodule

`default_nettype wire

// ==== sim/tb_pattern_ref.svh ====
`ifndef TB_PATTERN_REF_SVH
`define TB_PATTERN_REF_SVH

////////////////////////////////////////////////////////////////////////////
// Expected colour for one active pixel
////////////////////////////////////////////////////////////////////////////

function automatic video_pkg::rgb_t pixel_ref(input video_pkg::mode_t mode, input int col,
		input int row, input int h_active);
	logic [7:0]      fine;
	logic [7:0]      coarse;
	logic [7:0]      hramp;
	logic [7:0]      vramp;
	int              bar;
	video_pkg::rgb_t bars [8];
	fine   = (((col >> 4) & 1) != ((row >> 4) & 1)) ? 8'h00 : 8'hff;
	coarse = (((col >> 6) & 1) != ((row >> 6) & 1)) ? 8'h00 : 8'hff;
	hramp  = 8'(col % 256);
	vramp  = 8'((row >> 1) % 256); // Row bits 8 to 1
	bars   = '{24'hff0000, 24'h00ff00, 24'h0000ff, 24'hff00ff,
		24'hffff00, 24'h00ffff, 24'hffffff, 24'h000000};
	bar    = col / (h_active / 8);
	if (bar > 7)
		bar = 7; // Columns past the last full bar
	case (mode)
		4'd0:    return 24'h000000;
		4'd1:    return 24'hffffff;
		4'd2:    return 24'hff0000;
		4'd3:    return 24'h00ff00;
		4'd4:    return 24'h0000ff;
		4'd5:    return {fine, fine, fine};
		4'd6:    return {coarse, coarse, coarse};
		4'd7:    return {hramp, hramp, hramp};
		4'd8:    return {vramp, vramp, vramp};
		4'd9:    return {hramp, 8'h00, 8'h00};
		4'd10:   return {8'h00, hramp, 8'h00};
		4'd11:   return {8'h00, 8'h00, hramp};
		4'd12:   return bars[bar];
		default: return 24'h000000;
	endcase
endfunction

`endif

// ==== sim/tb_hdmi_pattern.sv ====
`default_nettype none

module tb_hdmi_pattern;
	timeunit 1ns;
	timeprecision 1ps;
	import video_pkg::*;

	`include "tb_pattern_ref.svh"

	localparam int H_ACTIVE = 64;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 8;
	localparam int V_ACTIVE = 24;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 3;
	localparam int DEBOUNCE = 5;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_NS = 20 * H_TOTAL * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
	// Two frames for each of the 16 mode checks plus margin, and all button presses
	localparam longint WATCHDOG_NS = longint'(FRAME_NS) * 36 + 20 * (16 * 60 + 400);

	logic        pix_clk;
	logic        reset;
	logic        button;
	logic [7:0]  red;
	logic [7:0]  green;
	logic [7:0]  blue;
	logic        hsync;
	logic        vsync;
	logic        de;
	mode_t       mode;

	int          pixel_errors = 0;
	int          timing_errors = 0;
	int          mode_errors = 0;
	int          pixel_checks = 0;
	mode_t       expected_mode;

	// Monitor outputs to the comparison process
	logic        pix_valid;
	int          pix_col;
	int          pix_row;
	rgb_t        pix_rgb;
	mode_t       pix_mode;

	hdmi_pattern_top #(
		.H_ACTIVE        (H_ACTIVE),
		.H_FRONT         (H_FRONT),
		.H_SYNC          (H_SYNC),
		.H_BACK          (H_BACK),
		.V_ACTIVE        (V_ACTIVE),
		.V_FRONT         (V_FRONT),
		.V_SYNC          (V_SYNC),
		.V_BACK          (V_BACK),
		.DEBOUNCE_CYCLES (DEBOUNCE)
	) hdmi_pattern_top_inst (
		.pix_clk (pix_clk),
		.reset   (reset),
		.button  (button),
		.red     (red),
		.green   (green),
		.blue    (blue),
		.hsync   (hsync),
		.vsync   (vsync),
		.de      (de),
		.mode    (mode)
	);

	initial begin
		pix_clk = 1'b0;
		forever #10 pix_clk = ~pix_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pin monitor, sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////

	logic  seen_sync;
	logic  frame_seen;
	logic  hs_prev;
	logic  vs_prev;
	logic  de_prev;
	int    hs_low;
	int    vs_low;
	int    de_cnt;
	int    lines_done;
	mode_t frame_mode;

	always @(negedge pix_clk) begin
		if (reset) begin
			seen_sync = 1'b0;
			frame_seen = 1'b0;
			hs_prev = 1'b1;
			vs_prev = 1'b1;
			de_prev = 1'b0;
			hs_low = 0;
			vs_low = 0;
			de_cnt = 0;
			lines_done = 0;
			pix_valid <= 1'b0;
		end else begin
			if (!seen_sync && hsync && vsync) begin // Idle pins before the first pulse
				assert (!de && mode == 4'd0)
				else begin
					timing_errors++;
					$display("error %0t: de %0b mode %0d before first sync, expected 0 0",
						$time, de, mode);
				end
			end else begin
				seen_sync = 1'b1;
			end
			if (!hsync) begin
				hs_low++;
			end else if (!hs_prev) begin
				assert (hs_low == H_SYNC)
				else begin
					timing_errors++;
					$display("error %0t: hsync low cycles %0d, expected %0d",
						$time, hs_low, H_SYNC);
				end
				hs_low = 0;
			end
			if (!vsync) begin
				vs_low++;
			end else if (!vs_prev) begin
				assert (vs_low == V_SYNC * H_TOTAL)
				else begin
					timing_errors++;
					$display("error %0t: vsync low cycles %0d, expected %0d",
						$time, vs_low, V_SYNC * H_TOTAL);
				end
				vs_low = 0;
			end
			if (vs_prev && !vsync) begin // New frame
				if (frame_seen) begin
					assert (lines_done == V_ACTIVE)
					else begin
						timing_errors++;
						$display("error %0t: active lines %0d, expected %0d",
							$time, lines_done, V_ACTIVE);
					end
				end
				frame_seen = 1'b1;
				lines_done = 0;
			end
			if (de) begin
				if (!de_prev) begin
					de_cnt = 0;
					if (lines_done == 0)
						frame_mode = mode;
				end
				assert (mode == frame_mode)
				else begin
					mode_errors++;
					$display("error %0t: mode %0d, expected %0d within frame",
						$time, mode, frame_mode);
				end
				pix_valid <= frame_seen;
				pix_col <= de_cnt;
				pix_row <= lines_done;
				pix_rgb <= {red, green, blue};
				pix_mode <= frame_mode;
				de_cnt++;
			end else begin
				if (de_prev) begin
					assert (de_cnt == H_ACTIVE)
					else begin
						timing_errors++;
						$display("error %0t: de high cycles %0d, expected %0d",
							$time, de_cnt, H_ACTIVE);
					end
					lines_done++;
				end
				assert ({red, green, blue} == 24'h0)
				else begin
					pixel_errors++;
					$display("error %0t: colour %06h while blanked, expected 000000",
						$time, {red, green, blue});
				end
				pix_valid <= 1'b0;
			end
			hs_prev = hsync;
			vs_prev = vsync;
			de_prev = de;
		end
	end

	// Compares each captured active pixel
	always @(posedge pix_clk) begin
		if (pix_valid) begin
			pixel_checks++;
			assert (pix_rgb == pixel_ref(pix_mode, pix_col, pix_row, H_ACTIVE))
			else begin
				pixel_errors++;
				$display("error %0t: pixel (%0d,%0d) mode %0d got %06h expected %06h",
					$time, pix_col, pix_row, pix_mode, pix_rgb,
					pixel_ref(pix_mode, pix_col, pix_row, H_ACTIVE));
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic hold_button(input int press_len, input int release_len);
		@(posedge pix_clk);
		button <= 1'b1;
		repeat (press_len) @(posedge pix_clk);
		button <= 1'b0;
		repeat (release_len) @(posedge pix_clk);
	endtask

	// Second vsync edge leaves one whole frame in the new mode
	task automatic wait_two_frames();
		@(negedge vsync);
		@(negedge vsync);
	endtask

	task automatic check_mode();
		assert (mode == expected_mode)
		else begin
			mode_errors++;
			$display("error %0t: mode %0d, expected %0d", $time, mode, expected_mode);
		end
	endtask

	initial begin
		void'($urandom(32'h67a1));
		reset = 1'b1;
		button = 1'b0;
		expected_mode = 4'd0;
		repeat (2) @(posedge pix_clk);
		reset <= 1'b0;
		wait_two_frames();
		check_mode();
		for (int i = 0; i < NUM_MODES; i++) begin
			hold_button(8 + int'($urandom % 33), 2 + int'($urandom % 9));
			expected_mode = (expected_mode == 4'd12) ? 4'd0 : expected_mode + 4'd1;
			wait_two_frames();
			check_mode();
		end
		hold_button(DEBOUNCE - 1, 4); // One cycle short of a step
		// Glitches
		repeat (3) hold_button(1 + int'($urandom % (DEBOUNCE - 1)), 2 + int'($urandom % 9));
		wait_two_frames();
		check_mode();
		hold_button(300, 4);
		expected_mode = 4'd1;
		wait_two_frames();
		check_mode();
		$display("pixels checked %0d, errors pixel %0d timing %0d mode %0d",
			pixel_checks, pixel_errors, timing_errors, mode_errors);
		if (pixel_errors + timing_errors + mode_errors == 0 && pixel_checks > 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run hung waiting for the raster");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
hw/video_pkg.sv
hw/video_timing.sv
hw/mode_select.sv
hw/pattern_gen.sv
hw/video_out.sv
hw/hdmi_pattern_top.sv
sim/tb_hdmi_pattern.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pattern source testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --top-module tb_hdmi_pattern -f files.f -o vsim > build.log 2>&1 &&
./obj_dir/vsim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx '>>> PASS' sim.log && exit 0 || exit 1
